/* bench/clk_gen.sv */
// Clock and reset source for the shift coprocessor testbench.
// 20 ns clock, reset held high for the first 16 rising edges.

`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic reset
);
  localparam int half_period = 10;
  localparam int reset_cycles = 16;
  localparam int drive_delay = 2;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
  end

endmodule

/* bench/shift_tb.sv */
// Testbench for the shift coprocessor.
// Drives the Wishbone port, compares results and flags with a bit-level
// reference model and covers queueing, back-pressure and result release.

`timescale 1ns/1ps

module shift_tb;
  import shift_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // About 400 bus requests of at most 10 cycles each, reset included.
  localparam int request_budget = 400;
  localparam int cycles_per_request = 10;
  localparam int timeout_cycles = request_budget * cycles_per_request;
  localparam int drive_delay = 2;

  logic              clk;
  logic              reset;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [addr_w-1:0] adr;
  logic [wb_w-1:0]   dat_w;
  logic [wb_w-1:0]   dat_r;
  logic              ack;
  logic [15:0]       lfsr_state = 16'd58;
  int                cycles = 0;

  clk_gen u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  shift_top DUT (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
      $display("Checks failed");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Bus master. Every task starts and ends 2 ns after a rising edge.
  // The request stays up through the edge that samples ack.
  task automatic wb_write(input logic [addr_w-1:0] a, input logic [wb_w-1:0] d);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = a;
    dat_w = d;
    @(posedge clk);
    #drive_delay;
    while (!ack) begin
      @(posedge clk);
      #drive_delay;
    end
    @(posedge clk);
    #drive_delay;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wb_read(input logic [addr_w-1:0] a, output logic [wb_w-1:0] d);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = a;
    @(posedge clk);
    #drive_delay;
    while (!ack) begin
      @(posedge clk);
      #drive_delay;
    end
    d = dat_r;
    @(posedge clk);
    #drive_delay;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "Stopped at the first error.");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Galois LFSR, one step per bit taken.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Only three kinds exist, so code 3 is drawn again.
  task automatic pick_kind(output logic [1:0] kind);
    logic [63:0] v;
    draw_bits(2, v);
    while (v[1:0] == 2'd3) begin
      draw_bits(2, v);
    end
    kind = v[1:0];
  endtask

  // Reference model, built bit by bit over the active width.
  // Returns {carry, sign, zero, parity, result}.
  function automatic logic [67:0] ref_shift(input logic [63:0] operand,
      input logic [5:0] count, input logic [1:0] kind, input logic wide);
    int          w;
    int          n;
    int          i;
    logic [63:0] a;
    logic [63:0] r;
    logic        c;
    w = wide ? 64 : 32;
    n = wide ? int'(count) : int'(count[4:0]);
    a = wide ? operand : {32'd0, operand[31:0]};
    r = '0;
    c = 1'b0;
    for (i = 0; i < w; i++) begin
      if (kind == shl) begin
        if (i >= n) r[i] = a[i - n];
      end else if (i + n < w) begin
        r[i] = a[i + n];
      end else if (kind == sar) begin
        r[i] = a[w - 1];
      end
    end
    if (n != 0) begin
      c = (kind == shl) ? a[w - n] : a[n - 1];
    end
    return {c, r[w - 1], r == 64'd0, ^r, r};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  task automatic issue_op(input logic [63:0] operand, input logic [5:0] count,
                          input logic [1:0] kind, input logic wide);
    logic [wb_w-1:0] cmd_word;
    cmd_word = '0;
    cmd_word[cmd_count_msb:cmd_count_lsb] = count;
    cmd_word[cmd_kind_msb:cmd_kind_lsb] = kind;
    cmd_word[cmd_wide_bit] = wide;
    wb_write(addr_opa_lo, operand[31:0]);
    wb_write(addr_opa_hi, operand[63:32]);
    wb_write(addr_cmd, cmd_word);
  endtask

  // Polls status until a result is held, then reads and releases it.
  task automatic read_back(input string name, input logic [67:0] expected,
                           output logic [63:0] res, output logic [3:0] flg);
    logic [wb_w-1:0] st;
    logic [wb_w-1:0] lo;
    logic [wb_w-1:0] hi;
    st = '0;
    while (!st[stat_valid_bit]) begin
      wb_read(addr_status, st);
    end
    wb_read(addr_res_lo, lo);
    wb_read(addr_res_hi, hi);
    res = {hi, lo};
    flg = st[stat_flags_msb:stat_flags_lsb];
    expect_equal({name, " result"}, expected[63:0], res);
    expect_equal({name, " flags"}, {60'd0, expected[67:64]}, {60'd0, flg});
  endtask

  task automatic run_shift(input string name, input logic [63:0] operand,
      input logic [5:0] count, input logic [1:0] kind, input logic wide,
      output logic [63:0] res, output logic [3:0] flg);
    issue_op(operand, count, kind, wide);
    read_back(name, ref_shift(operand, count, kind, wide), res, flg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  task automatic check_reset_state();
    logic [wb_w-1:0] st;
    wb_read(addr_status, st);
    expect_equal("reset status", 64'd0, {32'd0, st});
    wb_read(3'd6, st);
    expect_equal("unmapped read", 64'd0, {32'd0, st});
  endtask

  task automatic random_wide_test();
    logic [63:0] operand;
    logic [63:0] v;
    logic [1:0]  kind;
    logic [63:0] res;
    logic [3:0]  flg;
    int          k;
    for (k = 0; k < 40; k++) begin
      draw_bits(64, operand);
      draw_bits(6, v);
      pick_kind(kind);
      run_shift($sformatf("random 64-bit %0d", k), operand, v[5:0], kind, 1'b1, res, flg);
    end
  endtask

  // Counts of 32 and up, which the unit folds into 0 to 31.
  task automatic narrow_test();
    logic [63:0] operand;
    logic [63:0] v;
    logic [1:0]  kind;
    logic [63:0] res;
    logic [3:0]  flg;
    int          k;
    for (k = 0; k < 16; k++) begin
      draw_bits(64, operand);
      draw_bits(5, v);
      pick_kind(kind);
      run_shift($sformatf("32-bit %0d", k), operand, {1'b1, v[4:0]}, kind, 1'b0, res, flg);
      expect_equal($sformatf("32-bit %0d upper half", k), 64'd0, {32'd0, res[63:32]});
    end
  endtask

  task automatic edge_count_test();
    logic [63:0] res;
    logic [3:0]  flg;
    run_shift("count 0", 64'h0123_4567_89AB_CDEF, 6'd0, shl, 1'b1, res, flg);
    expect_equal("count 0 operand kept", 64'h0123_4567_89AB_CDEF, res);
    expect_equal("count 0 carry", 64'd0, {63'd0, flg[3]});
    run_shift("sar by 63", 64'h8000_0000_0000_1234, 6'd63, sar, 1'b1, res, flg);
    expect_equal("sar by 63 all ones", {64{1'b1}}, res);
    expect_equal("sar by 63 sign", 64'd1, {63'd0, flg[2]});
    run_shift("shift to zero", 64'h1, 6'd1, shr, 1'b1, res, flg);
    expect_equal("shift to zero flag", 64'd1, {63'd0, flg[1]});
    run_shift("32-bit to zero", 64'hFFFF_FFFF_8000_0000, 6'd1, shl, 1'b0, res, flg);
    expect_equal("32-bit to zero flag", 64'd1, {63'd0, flg[1]});
  endtask

  // The first command goes straight to the unit, the next four fill the FIFO.
  task automatic queue_test();
    logic [63:0]     opd [6];
    logic [5:0]      cnt [6];
    logic [1:0]      knd [6];
    logic [67:0]     expected [6];
    logic [63:0]     v;
    logic [1:0]      kind;
    logic [wb_w-1:0] st;
    logic [63:0]     res;
    logic [3:0]      flg;
    int              k;
    for (k = 0; k < 6; k++) begin
      draw_bits(64, v);
      opd[k] = v;
      draw_bits(6, v);
      cnt[k] = v[5:0];
      pick_kind(kind);
      knd[k] = kind;
      expected[k] = ref_shift(opd[k], cnt[k], knd[k], 1'b1);
    end
    for (k = 0; k < 5; k++) begin
      issue_op(opd[k], cnt[k], knd[k], 1'b1);
    end
    wb_read(addr_status, st);
    expect_equal("full after five", 64'd1, {63'd0, st[stat_full_bit]});
    for (k = 0; k < 6; k++) begin
      read_back($sformatf("queued %0d", k), expected[k], res, flg);
      if (k == 0) begin
        // One result read made room, so the sixth command is accepted.
        issue_op(opd[5], cnt[5], knd[5], 1'b1);
        wb_read(addr_status, st);
        expect_equal("full after sixth", 64'd1, {63'd0, st[stat_full_bit]});
      end
    end
  endtask

  task automatic release_test();
    logic [67:0]     expected;
    logic [wb_w-1:0] st;
    logic [wb_w-1:0] lo;
    logic [wb_w-1:0] hi;
    expected = ref_shift(64'hF0F0_0000_1234_5678, 6'd4, shr, 1'b1);
    issue_op(64'hF0F0_0000_1234_5678, 6'd4, shr, 1'b1);
    st = '0;
    while (!st[stat_valid_bit]) begin
      wb_read(addr_status, st);
    end
    wb_read(addr_res_lo, lo);
    wb_read(addr_status, st);
    expect_equal("valid after res_lo", 64'd1, {63'd0, st[stat_valid_bit]});
    wb_read(addr_res_hi, hi);
    expect_equal("release result", expected[63:0], {hi, lo});
    wb_read(addr_status, st);
    expect_equal("valid after res_hi", 64'd0, {63'd0, st[stat_valid_bit]});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    @(negedge reset);
    @(posedge clk);
    #drive_delay;
    check_reset_state();
    random_wide_test();
    narrow_test();
    edge_count_test();
    queue_test();
    release_test();
    $display("All checks passed");
    $finish;
  end

endmodule

/* filelist.f */
logic/shift_pkg.sv
logic/shift_op_if.sv
logic/wb_shift_port.sv
logic/op_fifo.sv
logic/shift_exec.sv
logic/shift_top.sv
bench/clk_gen.sv
bench/shift_tb.sv

/* logic/op_fifo.sv */
// Operation FIFO of the shift coprocessor.
// Circular buffer between the bus port and the execution unit.

`timescale 1ns/1ps

module op_fifo (
  input  logic      clk,
  input  logic      reset,
  shift_op_if.pop   in,
  shift_op_if.push  out,
  output logic      full
);
  import shift_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int count_w = $clog2(fifo_depth + 1);

  shift_op_t          mem [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count;
  logic               do_push;
  logic               do_pop;

  assign full = (count == count_w'(fifo_depth));
  assign in.ready = !full;
  assign out.valid = (count != '0);
  assign out.op = mem[rd_ptr];

  assign do_push = in.valid && in.ready;
  assign do_pop = out.valid && out.ready;

  // Storage.
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in.op;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Pointers and occupancy.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (reset) count <= count_w'(fifo_depth)
  );

  // A pop only drains what an earlier edge stored.
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (reset) do_pop |-> (count != '0) && (wr_ptr != rd_ptr || full)
  );

  // The bus port must hold its offer while the FIFO refuses it.
  a_push_held: assert property (
    @(posedge clk) disable iff (reset)
    (in.valid && !in.ready) |=> (in.valid && $stable(in.op))
  );

endmodule

/* logic/shift_exec.sv */
// Shift execution unit.
// Shifts a 64 or 32-bit operand left or right, logically or
// arithmetically, and holds the result and flags until released.

`timescale 1ns/1ps

module shift_exec (
  input  logic                          clk,
  input  logic                          reset,
  shift_op_if.pop                       op,
  input  logic                          result_release,
  output logic [shift_pkg::data_w-1:0]  result,
  output shift_pkg::shift_flags_t       flags,
  output logic                          result_valid
);
  import shift_pkg::*;

  logic [5:0]        amount;
  logic [data_w-1:0] src;
  logic [data_w:0]   left_ext;
  logic [data_w:0]   right_ext;
  logic [data_w-1:0] shifted;
  logic [data_w-1:0] masked;
  logic              carry;
  logic              take;
  shift_flags_t      next_flags;

  // Only one result is held at a time.
  assign op.ready = !result_valid;
  assign take = op.valid && op.ready;

  // ~~~~~~~~~~~~~~~~~~~~
  // Operand preparation.
  always_comb begin
    // Narrow shifts only see the low five count bits.
    amount = op.op.wide ? op.op.count : {1'b0, op.op.count[4:0]};
    if (op.op.wide) begin
      src = op.op.operand;
    end else if (op.op.kind == sar) begin
      src = {{(data_w - narrow_w){op.op.operand[narrow_w-1]}},
             op.op.operand[narrow_w-1:0]};
    end else begin
      src = {{(data_w - narrow_w){1'b0}}, op.op.operand[narrow_w-1:0]};
    end
  end

  // Both directions carry one extra bit to catch the last bit out.
  always_comb begin
    left_ext = {1'b0, src} << amount;
    if (op.op.kind == sar) begin
      right_ext = $signed({src, 1'b0}) >>> amount;
    end else begin
      right_ext = {src, 1'b0} >> amount;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Result select.
  always_comb begin
    case (op.op.kind)
      shr, sar: begin
        shifted = right_ext[data_w:1];
        carry = right_ext[0];
      end
      default: begin
        shifted = left_ext[data_w-1:0];
        carry = op.op.wide ? left_ext[data_w] : left_ext[narrow_w];
      end
    endcase
    masked = op.op.wide ? shifted : {{(data_w - narrow_w){1'b0}}, shifted[narrow_w-1:0]};
  end

  // Flags over the active width. The upper half is zero when narrow.
  always_comb begin
    next_flags.carry = carry;
    next_flags.sign = op.op.wide ? masked[data_w-1] : masked[narrow_w-1];
    next_flags.zero = (masked == '0);
    next_flags.parity = ^masked;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Result holding register.
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      flags <= '0;
    end else if (take) begin
      result <= masked;
      flags <= next_flags;
    end
  end

  // A release with nothing held must not drop an operation taken on that edge.
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (take) begin
      result_valid <= 1'b1;
    end else if (result_release) begin
      result_valid <= 1'b0;
    end
  end

  // The host reads both halves over several requests.
  a_result_held: assert property (
    @(posedge clk) disable iff (reset) result_valid |=> $stable({result, flags})
  );

endmodule

/* logic/shift_op_if.sv */
// Operation link between coprocessor stages.
// Valid/ready handshake carrying one queued shift operation.

`timescale 1ns/1ps

interface shift_op_if;
  import shift_pkg::*;

  logic      valid;
  logic      ready;
  shift_op_t op;

  // Source side of a link.
  // It offers an operation and holds it until ready is seen.
  modport push (
    output valid,
    output op,
    input  ready
  );

  // Sink side of a link.
  // A transfer happens on an edge with valid and ready both high.
  modport pop (
    input  valid,
    input  op,
    output ready
  );

endinterface

/* logic/shift_pkg.sv */
// Shift coprocessor shared definitions.
// Holds the register map, the command word layout, the operation and
// flag types and the operation FIFO depth.

package shift_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Widths.
  localparam int data_w = 64;
  localparam int narrow_w = 32;
  localparam int wb_w = 32;
  localparam int addr_w = 3;

  // ~~~~~~~~~~~~~~~~~~~~
  // Word addresses of the register map.
  localparam logic [addr_w-1:0] addr_opa_lo = 3'd0;
  localparam logic [addr_w-1:0] addr_opa_hi = 3'd1;
  localparam logic [addr_w-1:0] addr_cmd = 3'd2;
  localparam logic [addr_w-1:0] addr_res_lo = 3'd3;
  localparam logic [addr_w-1:0] addr_res_hi = 3'd4;
  localparam logic [addr_w-1:0] addr_status = 3'd5;

  // Command word fields.
  localparam int cmd_count_lsb = 0;
  localparam int cmd_count_msb = 5;
  localparam int cmd_kind_lsb = 8;
  localparam int cmd_kind_msb = 9;
  localparam int cmd_wide_bit = 12;

  // Status word fields.
  localparam int stat_valid_bit = 0;
  localparam int stat_full_bit = 1;
  localparam int stat_flags_lsb = 4;
  localparam int stat_flags_msb = 7;

  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    shl = 2'd0,
    shr = 2'd1,
    sar = 2'd2
  } shift_kind_e;

  // One queued operation. Wide set means a 64-bit shift.
  typedef struct packed {
    logic [data_w-1:0] operand;
    logic [5:0]        count;
    shift_kind_e       kind;
    logic              wide;
  } shift_op_t;

  typedef struct packed {
    logic carry;
    logic sign;
    logic zero;
    logic parity;
  } shift_flags_t;

  localparam int fifo_depth = 4;

endpackage

/* logic/shift_top.sv */
// Shift coprocessor top level.
// Bus port feeds the operation FIFO, which feeds the execution unit.

`timescale 1ns/1ps

module shift_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [shift_pkg::addr_w-1:0]  adr,
  input  logic [shift_pkg::wb_w-1:0]    dat_w,
  output logic [shift_pkg::wb_w-1:0]    dat_r,
  output logic                          ack
);
  import shift_pkg::*;

  logic              full;
  logic [data_w-1:0] result;
  shift_flags_t      flags;
  logic              result_valid;
  logic              result_release;

  shift_op_if push_link ();
  shift_op_if pop_link ();

  // Producer.
  wb_shift_port u_port (
    .clk            (clk),
    .reset          (reset),
    .cyc            (cyc),
    .stb            (stb),
    .we             (we),
    .adr            (adr),
    .dat_w          (dat_w),
    .dat_r          (dat_r),
    .ack            (ack),
    .op             (push_link.push),
    .full           (full),
    .result         (result),
    .flags          (flags),
    .result_valid   (result_valid),
    .result_release (result_release)
  );

  // Buffer.
  op_fifo u_fifo (
    .clk   (clk),
    .reset (reset),
    .in    (push_link.pop),
    .out   (pop_link.push),
    .full  (full)
  );

  // Consumer.
  shift_exec u_exec (
    .clk            (clk),
    .reset          (reset),
    .op             (pop_link.pop),
    .result_release (result_release),
    .result         (result),
    .flags          (flags),
    .result_valid   (result_valid)
  );

endmodule

/* logic/wb_shift_port.sv */
// Wishbone classic slave of the shift coprocessor.
// Holds the operand registers, queues commands with wait states under
// back-pressure and returns results and status.

`timescale 1ns/1ps

module wb_shift_port (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           cyc,
  input  logic                           stb,
  input  logic                           we,
  input  logic [shift_pkg::addr_w-1:0]   adr,
  input  logic [shift_pkg::wb_w-1:0]     dat_w,
  output logic [shift_pkg::wb_w-1:0]     dat_r,
  output logic                           ack,
  shift_op_if.push                       op,
  input  logic                           full,
  input  logic [shift_pkg::data_w-1:0]   result,
  input  shift_pkg::shift_flags_t        flags,
  input  logic                           result_valid,
  output logic                           result_release
);
  import shift_pkg::*;

  logic                req;
  logic                cmd_wr;
  logic [wb_w-1:0]     opa_lo;
  logic [wb_w-1:0]     opa_hi;
  logic [wb_w-1:0]     status_word;
  logic [wb_w-1:0]     rd_word;
  shift_op_t           cmd_op;

  // A request is new until it has been acknowledged.
  assign req = cyc && stb && !ack;
  assign cmd_wr = req && we && (adr == addr_cmd);

  // ~~~~~~~~~~~~~~~~~~~~
  // Command push.
  always_comb begin
    cmd_op.operand = {opa_hi, opa_lo};
    cmd_op.count = dat_w[cmd_count_msb:cmd_count_lsb];
    cmd_op.kind = shift_kind_e'(dat_w[cmd_kind_msb:cmd_kind_lsb]);
    cmd_op.wide = dat_w[cmd_wide_bit];
  end

  // Held by the master until ack, so valid stays up while the FIFO refuses.
  assign op.valid = cmd_wr;
  assign op.op = cmd_op;

  // Reading the upper result half hands the result back to the unit.
  assign result_release = req && !we && (adr == addr_res_hi);

  // ~~~~~~~~~~~~~~~~~~~~
  // Operand registers.
  always_ff @(posedge clk) begin
    if (req && we) begin
      if (adr == addr_opa_lo) begin
        opa_lo <= dat_w;
      end
      if (adr == addr_opa_hi) begin
        opa_hi <= dat_w;
      end
    end
  end

  // Status layout.
  always_comb begin
    status_word = '0;
    status_word[stat_valid_bit] = result_valid;
    status_word[stat_full_bit] = full;
    status_word[stat_flags_msb:stat_flags_lsb] = flags;
  end

  always_comb begin
    case (adr)
      addr_opa_lo: rd_word = opa_lo;
      addr_opa_hi: rd_word = opa_hi;
      addr_res_lo: rd_word = result[wb_w-1:0];
      addr_res_hi: rd_word = result[data_w-1:wb_w];
      addr_status: rd_word = status_word;
      default:     rd_word = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Ack and read data.
  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      // A cmd write waits for the FIFO; the push lands on the ack edge.
      ack <= req && !(cmd_wr && !op.ready);
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      dat_r <= rd_word;
    end
  end

  a_ack_in_request: assert property (
    @(posedge clk) disable iff (reset) ack |-> (cyc && stb)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the shift coprocessor testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module shift_tb -f filelist.f -o shift_sim \
  && ./obj_dir/shift_sim \
  || { echo "Simulation did not pass"; exit 1; }
